/* rtl/decoder_defs.svh */
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// data path and address width
`define DEC_XLEN 32

// architectural register index width
`define DEC_REG_W 5

// reorder-buffer tag width, any positive value works
`define DEC_TAG_W 4

// width of the internal opcode handed to the back end
`define DEC_OP_W 6

// width of the major opcode field in bits 6..0
`define DEC_OPC_W 7

// width of the immediate format selector
`define DEC_FMT_W 3

// funct7 for the normal encoding of OP and shift immediates
`define DEC_F7_BASE 7'b0000000

// funct7 for SUB, SRA and SRAI
`define DEC_F7_ALT 7'b0100000

// tag the allocator restarts from after reset or clear
`define DEC_TAG_RESET '0

`endif

/* rtl/decoder_pkg.sv */
`default_nettype none

`include "decoder_defs.svh"

package decoder_pkg;

    // major opcodes of the RV32I base set
    typedef enum logic [`DEC_OPC_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LUI    = 7'b0110111
    } rv_opcode_e;

    // internal opcodes, numbered as the back end expects them
    typedef enum logic [`DEC_OP_W-1:0] {
        OP_ADD     = 6'd0,
        OP_SUB     = 6'd1,
        OP_AND     = 6'd2,
        OP_OR      = 6'd3,
        OP_XOR     = 6'd4,
        OP_SLL     = 6'd5,
        OP_SRL     = 6'd6,
        OP_SRA     = 6'd7,
        OP_SLT     = 6'd8,
        OP_SLTU    = 6'd9,
        OP_ADDI    = 6'd10,
        OP_ANDI    = 6'd11,
        OP_ORI     = 6'd12,
        OP_XORI    = 6'd13,
        OP_SLLI    = 6'd14,
        OP_SRLI    = 6'd15,
        OP_SRAI    = 6'd16,
        OP_SLTI    = 6'd17,
        OP_SLTIU   = 6'd18,
        OP_LB      = 6'd19,
        OP_LBU     = 6'd20,
        OP_LH      = 6'd21,
        OP_LHU     = 6'd22,
        OP_LW      = 6'd23,
        OP_SB      = 6'd24,
        OP_SH      = 6'd25,
        OP_SW      = 6'd26,
        OP_BEQ     = 6'd27,
        OP_BGE     = 6'd28,
        OP_BGEU    = 6'd29,
        OP_BLT     = 6'd30,
        OP_BLTU    = 6'd31,
        OP_BNE     = 6'd32,
        OP_JAL     = 6'd33,
        OP_JALR    = 6'd34,
        OP_AUIPC   = 6'd35,
        OP_LUI     = 6'd36,
        OP_NOTHING = 6'd37
    } dec_op_e;

    // how the immediate is cut out of the instruction word
    typedef enum logic [`DEC_FMT_W-1:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_SHAMT = 3'd2,
        IMM_S     = 3'd3,
        IMM_B     = 3'd4,
        IMM_J     = 3'd5,
        IMM_U     = 3'd6
    } imm_fmt_e;

    typedef struct packed {
        dec_op_e  op;
        imm_fmt_e fmt;
        logic     is_mem;
    } dec_ctrl_t;

    // one decoded instruction as it leaves the stage
    typedef struct packed {
        dec_op_e                op;
        logic [`DEC_REG_W-1:0]  rd;
        logic [`DEC_REG_W-1:0]  rs1;
        logic [`DEC_REG_W-1:0]  rs2;
        logic [`DEC_XLEN-1:0]   imm;
        logic [`DEC_XLEN-1:0]   pc;
        logic [`DEC_XLEN-1:0]   pc_next;
        logic [`DEC_TAG_W-1:0]  tag;
    } dispatch_pkt_t;

endpackage

`default_nettype wire

/* rtl/op_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module op_decode (
    input  wire logic [`DEC_XLEN-1:0] instruction,
    output decoder_pkg::dec_ctrl_t    ctrl
);

    decoder_pkg::rv_opcode_e opcode;
    decoder_pkg::dec_op_e    op;
    decoder_pkg::imm_fmt_e   fmt;
    logic                    is_mem;
    logic [2:0]              funct3;
    logic [6:0]              funct7;

    assign opcode = decoder_pkg::rv_opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        op     = decoder_pkg::OP_NOTHING;
        fmt    = decoder_pkg::IMM_NONE;
        is_mem = 1'b0;
        case (opcode)
            decoder_pkg::OPC_OP: begin
                // register ops carry no immediate at all
                fmt = decoder_pkg::IMM_NONE;
                if (funct7 == `DEC_F7_BASE) begin
                    case (funct3)
                        3'b000:  op = decoder_pkg::OP_ADD;
                        3'b001:  op = decoder_pkg::OP_SLL;
                        3'b010:  op = decoder_pkg::OP_SLT;
                        3'b011:  op = decoder_pkg::OP_SLTU;
                        3'b100:  op = decoder_pkg::OP_XOR;
                        3'b101:  op = decoder_pkg::OP_SRL;
                        3'b110:  op = decoder_pkg::OP_OR;
                        default: op = decoder_pkg::OP_AND;
                    endcase
                end else if (funct7 == `DEC_F7_ALT) begin
                    // only SUB and SRA exist with the alternate funct7
                    if (funct3 == 3'b000) begin
                        op = decoder_pkg::OP_SUB;
                    end else if (funct3 == 3'b101) begin
                        op = decoder_pkg::OP_SRA;
                    end
                end
            end
            decoder_pkg::OPC_OP_IMM: begin
                fmt = decoder_pkg::IMM_I;
                case (funct3)
                    3'b000: op = decoder_pkg::OP_ADDI;
                    3'b010: op = decoder_pkg::OP_SLTI;
                    3'b011: op = decoder_pkg::OP_SLTIU;
                    3'b100: op = decoder_pkg::OP_XORI;
                    3'b110: op = decoder_pkg::OP_ORI;
                    3'b111: op = decoder_pkg::OP_ANDI;
                    3'b001: begin
                        fmt = decoder_pkg::IMM_SHAMT;
                        if (funct7 == `DEC_F7_BASE) begin
                            op = decoder_pkg::OP_SLLI;
                        end
                    end
                    default: begin
                        // funct3 101 holds both right shifts, told apart by bit 30
                        fmt = decoder_pkg::IMM_SHAMT;
                        if (funct7 == `DEC_F7_BASE) begin
                            op = decoder_pkg::OP_SRLI;
                        end else if (funct7 == `DEC_F7_ALT) begin
                            op = decoder_pkg::OP_SRAI;
                        end
                    end
                endcase
            end
            decoder_pkg::OPC_LOAD: begin
                fmt    = decoder_pkg::IMM_I;
                is_mem = 1'b1;
                case (funct3)
                    3'b000:  op = decoder_pkg::OP_LB;
                    3'b001:  op = decoder_pkg::OP_LH;
                    3'b010:  op = decoder_pkg::OP_LW;
                    3'b100:  op = decoder_pkg::OP_LBU;
                    3'b101:  op = decoder_pkg::OP_LHU;
                    default: op = decoder_pkg::OP_NOTHING;
                endcase
            end
            decoder_pkg::OPC_STORE: begin
                fmt    = decoder_pkg::IMM_S;
                is_mem = 1'b1;
                case (funct3)
                    3'b000:  op = decoder_pkg::OP_SB;
                    3'b001:  op = decoder_pkg::OP_SH;
                    3'b010:  op = decoder_pkg::OP_SW;
                    default: op = decoder_pkg::OP_NOTHING;
                endcase
            end
            decoder_pkg::OPC_BRANCH: begin
                fmt = decoder_pkg::IMM_B;
                case (funct3)
                    3'b000:  op = decoder_pkg::OP_BEQ;
                    3'b001:  op = decoder_pkg::OP_BNE;
                    3'b100:  op = decoder_pkg::OP_BLT;
                    3'b101:  op = decoder_pkg::OP_BGE;
                    3'b110:  op = decoder_pkg::OP_BLTU;
                    3'b111:  op = decoder_pkg::OP_BGEU;
                    default: op = decoder_pkg::OP_NOTHING;
                endcase
            end
            decoder_pkg::OPC_JALR: begin
                fmt = decoder_pkg::IMM_I;
                if (funct3 == 3'b000) begin
                    op = decoder_pkg::OP_JALR;
                end
            end
            decoder_pkg::OPC_JAL: begin
                fmt = decoder_pkg::IMM_J;
                op  = decoder_pkg::OP_JAL;
            end
            decoder_pkg::OPC_AUIPC: begin
                fmt = decoder_pkg::IMM_U;
                op  = decoder_pkg::OP_AUIPC;
            end
            decoder_pkg::OPC_LUI: begin
                fmt = decoder_pkg::IMM_U;
                op  = decoder_pkg::OP_LUI;
            end
            default: begin
                op = decoder_pkg::OP_NOTHING;
            end
        endcase

        // an illegal word must not reach the load/store buffer or carry an offset
        if (op == decoder_pkg::OP_NOTHING) begin
            fmt    = decoder_pkg::IMM_NONE;
            is_mem = 1'b0;
        end

        ctrl.op     = op;
        ctrl.fmt    = fmt;
        ctrl.is_mem = is_mem;
    end

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module imm_gen (
    input  wire logic [`DEC_XLEN-1:0]   instruction,
    input  wire decoder_pkg::imm_fmt_e  fmt,
    output logic [`DEC_XLEN-1:0]        imm
);

    logic sign;

    // every signed format takes its sign from bit 31
    assign sign = instruction[31];

    always_comb begin
        case (fmt)
            decoder_pkg::IMM_I: begin
                imm = {{(`DEC_XLEN-12){sign}}, instruction[31:20]};
            end
            decoder_pkg::IMM_SHAMT: begin
                // shift amount is unsigned and only five bits wide
                imm = {{(`DEC_XLEN-5){1'b0}}, instruction[24:20]};
            end
            decoder_pkg::IMM_S: begin
                imm = {{(`DEC_XLEN-12){sign}}, instruction[31:25], instruction[11:7]};
            end
            decoder_pkg::IMM_B: begin
                imm = {{(`DEC_XLEN-13){sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            decoder_pkg::IMM_J: begin
                imm = {{(`DEC_XLEN-21){sign}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            decoder_pkg::IMM_U: begin
                imm = {instruction[31:12], 12'b0};
            end
            default: begin
                // register ops and illegal words
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/dispatch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module dispatch_stage (
    input  wire logic                  clk_in,
    input  wire logic                  rst_n,
    input  wire logic                  rdy_in,
    input  wire logic                  clear,
    input  wire logic                  fetch_valid,
    input  wire decoder_pkg::dec_ctrl_t ctrl,
    input  wire logic [`DEC_XLEN-1:0]  imm,
    input  wire logic [`DEC_XLEN-1:0]  instruction,
    input  wire logic [`DEC_XLEN-1:0]  pc,
    input  wire logic [`DEC_XLEN-1:0]  pc_next,
    output decoder_pkg::dispatch_pkt_t pkt,
    output logic                       rs_valid,
    output logic                       lsb_valid,
    output logic                       rob_valid
);

    logic [`DEC_TAG_W-1:0]     tag_cnt;
    logic                      accept;
    logic                      issue_q;
    logic                      lsb_q;
    decoder_pkg::dispatch_pkt_t pkt_d;

    // clear wins over a fetch arriving in the same cycle
    assign accept = fetch_valid & ~clear;

    always_comb begin
        pkt_d.op      = ctrl.op;
        pkt_d.rd      = instruction[11:7];
        pkt_d.rs1     = instruction[19:15];
        pkt_d.rs2     = instruction[24:20];
        pkt_d.imm     = imm;
        pkt_d.pc      = pc;
        pkt_d.pc_next = pc_next;
        pkt_d.tag     = tag_cnt;
    end

    // rdy_in low freezes everything including the strobes
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            pkt     <= '0;
            issue_q <= 1'b0;
            lsb_q   <= 1'b0;
            tag_cnt <= `DEC_TAG_RESET;
        end else if (rdy_in) begin
            if (accept) begin
                pkt     <= pkt_d;
                issue_q <= 1'b1;
                lsb_q   <= ctrl.is_mem;
                // wraps naturally at 2^DEC_TAG_W
                tag_cnt <= tag_cnt + 1'b1;
            end else begin
                issue_q <= 1'b0;
                lsb_q   <= 1'b0;
                if (clear) begin
                    tag_cnt <= `DEC_TAG_RESET;
                end
            end
        end
    end

    // every accepted instruction goes to both the stations and the ROB
    assign rs_valid  = issue_q;
    assign rob_valid = issue_q;
    assign lsb_valid = lsb_q;

endmodule

`default_nettype wire

/* rtl/decoder_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module decoder_top (
    input  wire logic                  clk_in,
    input  wire logic                  rst_n,
    input  wire logic                  rdy_in,
    input  wire logic                  clear,
    input  wire logic                  fetch_valid,
    input  wire logic [`DEC_XLEN-1:0]  pc,
    input  wire logic [`DEC_XLEN-1:0]  pc_next,
    input  wire logic [`DEC_XLEN-1:0]  instruction,
    output decoder_pkg::dispatch_pkt_t pkt,
    output logic                       rs_valid,
    output logic                       lsb_valid,
    output logic                       rob_valid
);

    decoder_pkg::dec_ctrl_t ctrl;
    logic [`DEC_XLEN-1:0]   imm;

    op_decode u_op_decode (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    imm_gen u_imm_gen (
        .instruction (instruction),
        .fmt         (ctrl.fmt),
        .imm         (imm)
    );

    dispatch_stage u_dispatch_stage (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .rdy_in      (rdy_in),
        .clear       (clear),
        .fetch_valid (fetch_valid),
        .ctrl        (ctrl),
        .imm         (imm),
        .instruction (instruction),
        .pc          (pc),
        .pc_next     (pc_next),
        .pkt         (pkt),
        .rs_valid    (rs_valid),
        .lsb_valid   (lsb_valid),
        .rob_valid   (rob_valid)
    );

endmodule

`default_nettype wire

/* tests/decoder_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module decoder_asserts (
    input wire logic                       clk_in,
    input wire logic                       rst_n,
    input wire logic                       rdy_in,
    input wire decoder_pkg::dispatch_pkt_t pkt,
    input wire logic                       rs_valid,
    input wire logic                       lsb_valid,
    input wire logic                       rob_valid
);

    // number of failed assertions so far
    int fail_count = 0;

    strobes_low_in_reset: assert property (
        @(posedge clk_in) !rst_n |-> !rs_valid && !lsb_valid && !rob_valid
    ) else begin
        fail_count++;
        $error("issue strobe high while reset is asserted");
    end

    // every accepted instruction takes a station slot and a ROB entry together
    rs_matches_rob: assert property (
        @(posedge clk_in) disable iff (!rst_n) rs_valid == rob_valid
    ) else begin
        fail_count++;
        $error("rs_valid and rob_valid differ");
    end

    lsb_needs_rs: assert property (
        @(posedge clk_in) disable iff (!rst_n) lsb_valid |-> rs_valid
    ) else begin
        fail_count++;
        $error("lsb_valid high without rs_valid");
    end

    outputs_hold_in_stall: assert property (
        @(posedge clk_in) disable iff (!rst_n)
        !rdy_in |=> $stable(pkt) && $stable(rs_valid) && $stable(lsb_valid) && $stable(rob_valid)
    ) else begin
        fail_count++;
        $error("outputs changed on a cycle with rdy_in low");
    end

endmodule

bind decoder_top decoder_asserts u_asserts (.*);

`default_nettype wire

/* tests/decoder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module decoder_tb;

    // RV32I major opcodes as the ISA encodes them
    localparam logic [6:0] R_OP     = 7'b0110011;
    localparam logic [6:0] I_OP     = 7'b0010011;
    localparam logic [6:0] LD_OP    = 7'b0000011;
    localparam logic [6:0] ST_OP    = 7'b0100011;
    localparam logic [6:0] BR_OP    = 7'b1100011;
    localparam logic [6:0] JALR_OP  = 7'b1100111;
    localparam logic [6:0] JAL_OP   = 7'b1101111;
    localparam logic [6:0] AUIPC_OP = 7'b0010111;
    localparam logic [6:0] LUI_OP   = 7'b0110111;
    localparam logic [6:0] F7B      = `DEC_F7_BASE;
    localparam logic [6:0] F7A      = `DEC_F7_ALT;

    // instruction layouts used by the encoder below
    localparam logic [2:0] FR  = 3'd0;
    localparam logic [2:0] FI  = 3'd1;
    localparam logic [2:0] FSH = 3'd2;
    localparam logic [2:0] FS  = 3'd3;
    localparam logic [2:0] FB  = 3'd4;
    localparam logic [2:0] FJ  = 3'd5;
    localparam logic [2:0] FU  = 3'd6;

    // {opcode, funct3, funct7, layout} for each internal op in back-end numbering
    localparam logic [19:0] OP_TABLE [37] = '{
        {R_OP, 3'd0, F7B, FR}, {R_OP, 3'd0, F7A, FR}, {R_OP, 3'd7, F7B, FR},
        {R_OP, 3'd6, F7B, FR}, {R_OP, 3'd4, F7B, FR}, {R_OP, 3'd1, F7B, FR},
        {R_OP, 3'd5, F7B, FR}, {R_OP, 3'd5, F7A, FR}, {R_OP, 3'd2, F7B, FR},
        {R_OP, 3'd3, F7B, FR}, {I_OP, 3'd0, F7B, FI}, {I_OP, 3'd7, F7B, FI},
        {I_OP, 3'd6, F7B, FI}, {I_OP, 3'd4, F7B, FI}, {I_OP, 3'd1, F7B, FSH},
        {I_OP, 3'd5, F7B, FSH}, {I_OP, 3'd5, F7A, FSH}, {I_OP, 3'd2, F7B, FI},
        {I_OP, 3'd3, F7B, FI}, {LD_OP, 3'd0, F7B, FI}, {LD_OP, 3'd4, F7B, FI},
        {LD_OP, 3'd1, F7B, FI}, {LD_OP, 3'd5, F7B, FI}, {LD_OP, 3'd2, F7B, FI},
        {ST_OP, 3'd0, F7B, FS}, {ST_OP, 3'd1, F7B, FS}, {ST_OP, 3'd2, F7B, FS},
        {BR_OP, 3'd0, F7B, FB}, {BR_OP, 3'd5, F7B, FB}, {BR_OP, 3'd7, F7B, FB},
        {BR_OP, 3'd4, F7B, FB}, {BR_OP, 3'd6, F7B, FB}, {BR_OP, 3'd1, F7B, FB},
        {JAL_OP, 3'd0, F7B, FJ}, {JALR_OP, 3'd0, F7B, FI}, {AUIPC_OP, 3'd0, F7B, FU},
        {LUI_OP, 3'd0, F7B, FU}
    };

    logic                       clk_in;
    logic                       rst_n;
    logic                       rdy_in;
    logic                       clear;
    logic                       fetch_valid;
    logic [`DEC_XLEN-1:0]       pc;
    logic [`DEC_XLEN-1:0]       pc_next;
    logic [`DEC_XLEN-1:0]       instruction;
    decoder_pkg::dispatch_pkt_t pkt;
    logic                       rs_valid;
    logic                       lsb_valid;
    logic                       rob_valid;

    decoder_pkg::dispatch_pkt_t exp_pkt;
    decoder_pkg::dispatch_pkt_t held_pkt;
    logic                       exp_mem;
    logic                       held_mem;
    logic [`DEC_XLEN-1:0]       cur_word;
    logic [`DEC_TAG_W-1:0]      exp_tag;
    int                         errors = 0;
    int                         checks = 0;
    int                         tests = 0;
    int                         failed_tests = 0;
    int                         start_errors = 0;
    string                      test_name;

    decoder_top uut (.*);

    initial begin
        clk_in = 1'b0;
        forever begin
            #50 clk_in = ~clk_in;
        end
    end

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_outputs(input decoder_pkg::dispatch_pkt_t e, input logic m);
        checks++;
        assert (rs_valid && rob_valid) else flag_mismatch("rs_valid or rob_valid low");
        assert (lsb_valid == m) else flag_mismatch($sformatf("lsb_valid %0b, expected %0b",
                                                              lsb_valid, m));
        assert (pkt.op == e.op) else flag_mismatch($sformatf("op %0d, expected %0d",
                                                              pkt.op, e.op));
        assert ({pkt.rd, pkt.rs1, pkt.rs2} == {e.rd, e.rs1, e.rs2})
            else flag_mismatch("register indices differ");
        assert (pkt.imm == e.imm) else flag_mismatch($sformatf("imm %h, expected %h",
                                                                pkt.imm, e.imm));
        assert (pkt.pc == e.pc && pkt.pc_next == e.pc_next)
            else flag_mismatch("pc or pc_next not passed through");
        assert (pkt.tag == e.tag) else flag_mismatch($sformatf("tag %0d, expected %0d",
                                                                pkt.tag, e.tag));
    endtask

    // waits for the issue strobe of the instruction just accepted
    task automatic wait_issue();
        int n = 0;
        do begin
            @(negedge clk_in);
            n++;
        end while (!rs_valid && n < 20);
        exp_pkt.tag = exp_tag;
        if (rs_valid) begin
            check_outputs(exp_pkt, exp_mem);
        end else begin
            $display("timeout at %0t: no issue strobe within 20 cycles", $time);
            errors++;
        end
        exp_tag++;
    endtask

    task automatic expect_word(input logic [31:0] w, input decoder_pkg::dec_op_e op,
                               input logic [31:0] imm, input logic mem);
        cur_word        = w;
        exp_pkt.op      = op;
        exp_pkt.rd      = w[11:7];
        exp_pkt.rs1     = w[19:15];
        exp_pkt.rs2     = w[24:20];
        exp_pkt.imm     = imm;
        exp_pkt.pc      = {30'($urandom), 2'b00};
        exp_pkt.pc_next = exp_pkt.pc + 32'd4;
        exp_mem         = mem;
    endtask

    // encodes a random instance of one internal op and records what it must decode to
    task automatic prepare_op(input int idx);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [2:0]  fmt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] e;
        {opc, f3, f7, fmt} = OP_TABLE[idx];
        rd  = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        v   = $urandom;
        case (fmt)
            FR:      w = {f7, rs2, rs1, f3, rd, opc};
            FI:      w = {v[11:0], rs1, f3, rd, opc};
            FSH:     w = {f7, v[4:0], rs1, f3, rd, opc};
            FS:      w = {v[11:5], rs2, rs1, f3, v[4:0], opc};
            FB:      w = {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], opc};
            FJ:      w = {v[20], v[10:1], v[11], v[19:12], rd, opc};
            default: w = {v[31:12], rd, opc};
        endcase
        case (fmt)
            FR:      e = '0;
            FI, FS:  e = {{20{v[11]}}, v[11:0]};
            FSH:     e = {27'd0, v[4:0]};
            FB:      e = {{19{v[12]}}, v[12:1], 1'b0};
            FJ:      e = {{11{v[20]}}, v[20:1], 1'b0};
            default: e = {v[31:12], 12'd0};
        endcase
        expect_word(w, decoder_pkg::dec_op_e'(idx), e, opc == LD_OP || opc == ST_OP);
    endtask

    task automatic drive_word();
        @(posedge clk_in);
        instruction <= cur_word;
        pc          <= exp_pkt.pc;
        pc_next     <= exp_pkt.pc_next;
        fetch_valid <= 1'b1;
    endtask

    task automatic send_and_check();
        drive_word();
        @(posedge clk_in);
        fetch_valid <= 1'b0;
        wait_issue();
    endtask

    task automatic issue_op(input int idx);
        prepare_op(idx);
        send_and_check();
    endtask

    task automatic issue_illegal(input logic [31:0] w);
        expect_word(w, decoder_pkg::OP_NOTHING, '0, 1'b0);
        send_and_check();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_in);
            fetch_valid <= 1'b0;
            @(negedge clk_in);
            checks++;
            assert (!rs_valid && !lsb_valid && !rob_valid)
                else flag_mismatch("strobe high on a cycle without an accepted fetch");
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == start_errors) begin
            $display("test %0d, %s: ok", tests, test_name);
        end else begin
            failed_tests++;
            $display("test %0d, %s: %0d errors", tests, test_name, errors - start_errors);
        end
    endtask

    initial begin
        int i;
        int n;
        void'($urandom(32'hf3d1_92e7));
        rst_n       = 1'b0;
        rdy_in      = 1'b1;
        clear       = 1'b0;
        fetch_valid = 1'b0;
        pc          = '0;
        pc_next     = '0;
        instruction = '0;
        exp_tag     = '0;
        repeat (5) @(posedge clk_in);
        rst_n <= 1'b1;

        start_test("register and immediate ALU ops");
        for (i = 0; i < 19; i++) begin
            issue_op(i);
        end
        // SLTIU with a negative immediate still sign-extends it
        expect_word({12'hf80, 5'($urandom), 3'd3, 5'($urandom), I_OP},
                    decoder_pkg::OP_SLTIU, 32'hffff_ff80, 1'b0);
        send_and_check();
        repeat (40) issue_op($urandom_range(0, 18));
        end_test();

        start_test("loads and stores");
        for (i = 19; i < 27; i++) begin
            issue_op(i);
        end
        repeat (24) issue_op($urandom_range(19, 26));
        end_test();

        start_test("branches, jumps and upper immediates");
        for (i = 27; i < 37; i++) begin
            issue_op(i);
        end
        repeat (30) issue_op($urandom_range(27, 36));
        end_test();

        start_test("illegal words");
        issue_illegal({25'($urandom), 7'b1111111});
        issue_illegal({F7A, 5'($urandom), 5'($urandom), 3'd7, 5'($urandom), R_OP});
        issue_illegal({F7A, 5'($urandom), 5'($urandom), 3'd1, 5'($urandom), I_OP});
        issue_illegal({12'($urandom), 5'($urandom), 3'd3, 5'($urandom), LD_OP});
        issue_illegal({12'($urandom), 5'($urandom), 3'd2, 5'($urandom), BR_OP});
        end_test();

        start_test("tag order, idle cycles and clear");
        for (i = 0; i < (1 << `DEC_TAG_W) + 3; i++) begin
            issue_op($urandom_range(0, 36));
            if (i % 3 == 0) begin
                idle_cycles(2);
            end
        end
        @(posedge clk_in);
        clear <= 1'b1;
        @(posedge clk_in);
        clear <= 1'b0;
        exp_tag = '0;
        idle_cycles(1);
        repeat (3) issue_op($urandom_range(0, 36));
        end_test();

        start_test("stall with rdy_in low");
        prepare_op($urandom_range(0, 36));
        drive_word();
        @(posedge clk_in);
        rdy_in      <= 1'b0;
        fetch_valid <= 1'b0;
        wait_issue();
        held_pkt = exp_pkt;
        held_mem = exp_mem;
        // a new fetch arrives while stalled and must wait for rdy_in
        prepare_op($urandom_range(0, 36));
        drive_word();
        n = $urandom_range(3, 8);
        repeat (n) begin
            @(negedge clk_in);
            check_outputs(held_pkt, held_mem);
        end
        @(posedge clk_in);
        rdy_in <= 1'b1;
        @(posedge clk_in);
        fetch_valid <= 1'b0;
        wait_issue();
        repeat (4) issue_op($urandom_range(0, 36));
        end_test();

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests, failed_tests, checks, errors, uut.u_asserts.fail_count);
        if (errors == 0 && uut.u_asserts.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/decoder_pkg.sv
rtl/op_decode.sv
rtl/imm_gen.sv
rtl/dispatch_stage.sv
rtl/decoder_top.sv
tests/decoder_asserts.sv
tests/decoder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the decoder testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module decoder_tb \
    && ./obj_dir/Vdecoder_tb +verilator+error+limit+100 | tee /dev/stderr \
        | grep -qF '*** TEST PASSED ***' \
    && echo "decoder simulation passed" \
    || { echo "decoder simulation failed"; exit 1; }
